// File: exec_pkg.sv
package exec_pkg;

    ////////////////////
    // Widths and divider constants
    ////////////////////

    localparam int XLEN = 32;

    // One shift-subtract step per dividend bit
    localparam int DIV_STEPS = 32;

    // Strobe, then load, then the steps, then done and the output register
    localparam int DIV_LATENCY = 34;

    ////////////////////
    // Types
    ////////////////////

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [3:0]      byte_en_t;

    // Decoded operation as handed over by the decode stage
    typedef enum logic [5:0] {
        NOP,
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        LUI,
        AUIPC,
        BEQ,
        BNE,
        BLT,
        BLTU,
        BGE,
        BGEU,
        JAL,
        JALR,
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW,
        DIV,
        DIVU,
        REM,
        REMU
    } op_e;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } div_state_e;

endpackage

// File: div_ctrl_if.sv
`timescale 1ns/1ps

interface div_ctrl_if;

    logic start;
    logic step;
    logic last;
    logic done;
    logic busy;

    modport fsm (
        output start,
        output step,
        output done,
        output busy,
        input  last
    );

    modport counter (
        input  start,
        input  step,
        output last
    );

    modport datapath (
        input  start,
        input  step
    );

endinterface

// File: alu.sv
`timescale 1ns/1ps

module alu (
    input  exec_pkg::op_e   op_i,
    input  exec_pkg::word_t rs1_i,
    input  exec_pkg::word_t operand_i,
    output exec_pkg::word_t sum_o,
    output exec_pkg::word_t result_o,
    output logic            take_branch_o
);

    exec_pkg::word_t diff;
    exec_pkg::word_t and_res;
    exec_pkg::word_t or_res;
    exec_pkg::word_t xor_res;
    exec_pkg::word_t sll_res;
    exec_pkg::word_t srl_res;
    exec_pkg::word_t sra_res;
    logic [4:0]      shamt;
    logic            equal;
    logic            less;
    logic            less_u;

    // Shift amount is the low five bits only
    assign shamt = operand_i[4:0];

    always_comb begin
        sum_o   = rs1_i + operand_i;
        diff    = rs1_i - operand_i;
        and_res = rs1_i & operand_i;
        or_res  = rs1_i | operand_i;
        xor_res = rs1_i ^ operand_i;
        sll_res = rs1_i << shamt;
        srl_res = rs1_i >> shamt;
        sra_res = $signed(rs1_i) >>> shamt;
        equal   = (rs1_i == operand_i);
        less    = ($signed(rs1_i) < $signed(operand_i));
        less_u  = (rs1_i < operand_i);
    end

    always_comb begin
        unique case (op_i)
            exec_pkg::SUB:  result_o = diff;
            exec_pkg::AND:  result_o = and_res;
            exec_pkg::OR:   result_o = or_res;
            exec_pkg::XOR:  result_o = xor_res;
            exec_pkg::SLL:  result_o = sll_res;
            exec_pkg::SRL:  result_o = srl_res;
            exec_pkg::SRA:  result_o = sra_res;
            exec_pkg::SLT:  result_o = exec_pkg::word_t'(less);
            exec_pkg::SLTU: result_o = exec_pkg::word_t'(less_u);
            exec_pkg::LUI:  result_o = operand_i;
            default:        result_o = sum_o;
        endcase
    end

    // Branch decision, jumps always taken
    always_comb begin
        unique case (op_i)
            exec_pkg::BEQ:  take_branch_o = equal;
            exec_pkg::BNE:  take_branch_o = !equal;
            exec_pkg::BLT:  take_branch_o = less;
            exec_pkg::BLTU: take_branch_o = less_u;
            exec_pkg::BGE:  take_branch_o = !less;
            exec_pkg::BGEU: take_branch_o = !less_u;
            exec_pkg::JAL,
            exec_pkg::JALR: take_branch_o = 1'b1;
            default:        take_branch_o = 1'b0;
        endcase
    end

endmodule

// File: mem_access.sv
`timescale 1ns/1ps

module mem_access (
    input  exec_pkg::op_e      op_i,
    input  logic               valid_i,
    input  exec_pkg::word_t    address_i,
    input  exec_pkg::word_t    store_data_i,
    output exec_pkg::word_t    mem_address_o,
    output logic               mem_read_enable_o,
    output exec_pkg::byte_en_t mem_write_enable_o,
    output exec_pkg::word_t    mem_write_data_o
);

    exec_pkg::byte_en_t lanes;
    logic               is_load;

    // Memory is word addressed, the lanes pick the bytes
    assign mem_address_o = {address_i[31:2], 2'b00};

    assign is_load = op_i inside {exec_pkg::LB, exec_pkg::LBU, exec_pkg::LH,
                                  exec_pkg::LHU, exec_pkg::LW};

    assign mem_read_enable_o = valid_i && is_load;

    always_comb begin
        unique case (op_i)
            exec_pkg::SB: begin
                unique case (address_i[1:0])
                    2'b11:   lanes = 4'b1000;
                    2'b10:   lanes = 4'b0100;
                    2'b01:   lanes = 4'b0010;
                    default: lanes = 4'b0001;
                endcase
            end
            exec_pkg::SH: lanes = address_i[1] ? 4'b1100 : 4'b0011;
            exec_pkg::SW: lanes = 4'b1111;
            default:      lanes = 4'b0000;
        endcase
    end

    assign mem_write_enable_o = valid_i ? lanes : 4'b0000;

    // Narrow stores repeat across all lanes
    always_comb begin
        unique case (op_i)
            exec_pkg::SB: mem_write_data_o = {4{store_data_i[7:0]}};
            exec_pkg::SH: mem_write_data_o = {2{store_data_i[15:0]}};
            default:      mem_write_data_o = store_data_i;
        endcase
    end

endmodule

// File: div_fsm.sv
`timescale 1ns/1ps

module div_fsm (
    input  logic          clk,
    input  logic          reset_n,
    input  exec_pkg::op_e op_i,
    input  logic          valid_i,
    div_ctrl_if.fsm       ctrl
);

    exec_pkg::div_state_e state_q;
    exec_pkg::div_state_e state_d;
    logic                 is_div;

    assign is_div = op_i inside {exec_pkg::DIV, exec_pkg::DIVU,
                                 exec_pkg::REM, exec_pkg::REMU};

    // Accept a new division only when idle
    assign ctrl.start = valid_i && is_div && (state_q == exec_pkg::IDLE);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            exec_pkg::IDLE: begin
                if (ctrl.start) begin
                    state_d = exec_pkg::RUN;
                end
            end
            exec_pkg::RUN: begin
                if (ctrl.last) begin
                    state_d = exec_pkg::DONE;
                end
            end
            exec_pkg::DONE: state_d = exec_pkg::IDLE;
            default:        state_d = exec_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= exec_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // One shift-subtract step per RUN cycle
    assign ctrl.step = (state_q == exec_pkg::RUN);

    // Result settles in DONE, the top registers it there
    assign ctrl.done = (state_q == exec_pkg::DONE);

    // Held from the cycle after the strobe until the result is written
    assign ctrl.busy = (state_q != exec_pkg::IDLE);

endmodule

// File: div_step_counter.sv
`timescale 1ns/1ps

module div_step_counter (
    input  logic        clk,
    input  logic        reset_n,
    div_ctrl_if.counter ctrl
);

    localparam int CNT_W = $clog2(exec_pkg::XLEN);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            count <= '0;
        end else if (ctrl.start) begin
            count <= '0;
        end else if (ctrl.step) begin
            count <= count + 1'b1;
        end
    end

    // Final step of the division
    assign ctrl.last = (count == CNT_W'(exec_pkg::DIV_STEPS - 1));

endmodule

// File: div_datapath.sv
`timescale 1ns/1ps

module div_datapath (
    input  logic            clk,
    input  logic            reset_n,
    input  exec_pkg::op_e   op_i,
    input  exec_pkg::word_t dividend_i,
    input  exec_pkg::word_t divisor_i,
    div_ctrl_if.datapath    ctrl,
    output exec_pkg::word_t result_o
);

    localparam int W = exec_pkg::XLEN;

    exec_pkg::word_t quo;
    exec_pkg::word_t rem;
    exec_pkg::word_t dvsr;
    logic [W:0]      partial;
    logic [W+1:0]    diff;
    logic            is_signed;
    logic            neg_quo;
    logic            neg_rem;
    logic            is_rem;

    assign is_signed = op_i inside {exec_pkg::DIV, exec_pkg::REM};

    // Shift in the next dividend bit and try the subtraction
    assign partial = {rem, quo[W-1]};
    assign diff    = {1'b0, partial} - {2'b00, dvsr};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            neg_quo <= 1'b0;
            neg_rem <= 1'b0;
            is_rem  <= 1'b0;
        end else if (ctrl.start) begin
            neg_quo <= is_signed && (dividend_i[W-1] ^ divisor_i[W-1]) && (divisor_i != '0);
            neg_rem <= is_signed && dividend_i[W-1];
            is_rem  <= op_i inside {exec_pkg::REM, exec_pkg::REMU};
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.start) begin
            quo  <= (is_signed && dividend_i[W-1]) ? -dividend_i : dividend_i;
            dvsr <= (is_signed && divisor_i[W-1]) ? -divisor_i : divisor_i;
            rem  <= '0;
        end else if (ctrl.step) begin
            if (!diff[W+1]) begin
                rem <= diff[W-1:0];
                quo <= {quo[W-2:0], 1'b1};
            end else begin
                // Restore, the divisor did not fit
                rem <= partial[W-1:0];
                quo <= {quo[W-2:0], 1'b0};
            end
        end
    end

    // Sign fix-up, remainder follows the dividend
    always_comb begin
        if (is_rem) begin
            result_o = neg_rem ? -rem : rem;
        end else begin
            result_o = neg_quo ? -quo : quo;
        end
    end

endmodule

// File: execute_top.sv
`timescale 1ns/1ps

module execute_top (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               op_valid_i,
    input  exec_pkg::op_e      op_i,
    input  exec_pkg::word_t    rs1_data_i,
    input  exec_pkg::word_t    rs2_data_i,
    input  exec_pkg::word_t    second_operand_i,
    input  exec_pkg::reg_idx_t rd_i,
    input  exec_pkg::word_t    pc_next_i,
    input  exec_pkg::word_t    jump_imm_target_i,
    output logic               hold_o,
    output logic               write_enable_o,
    output exec_pkg::reg_idx_t rd_o,
    output exec_pkg::word_t    result_o,
    output logic               jump_o,
    output exec_pkg::word_t    jump_target_o,
    output exec_pkg::word_t    mem_address_o,
    output logic               mem_read_enable_o,
    output exec_pkg::byte_en_t mem_write_enable_o,
    output exec_pkg::word_t    mem_write_data_o
);

    exec_pkg::word_t    sum;
    exec_pkg::word_t    alu_result;
    exec_pkg::word_t    div_result;
    exec_pkg::word_t    result;
    exec_pkg::reg_idx_t div_rd;
    logic               take_branch;
    logic               issue_valid;
    logic               write_enable;

    div_ctrl_if div_ctrl ();

    // Strobes during hold are dropped
    assign issue_valid = op_valid_i && !div_ctrl.busy;
    assign hold_o      = div_ctrl.busy;

    ////////////////////
    // Datapath units
    ////////////////////

    alu u_alu (
        .op_i          (op_i),
        .rs1_i         (rs1_data_i),
        .operand_i     (second_operand_i),
        .sum_o         (sum),
        .result_o      (alu_result),
        .take_branch_o (take_branch)
    );

    mem_access u_mem_access (
        .op_i               (op_i),
        .valid_i            (issue_valid),
        .address_i          (sum),
        .store_data_i       (rs2_data_i),
        .mem_address_o      (mem_address_o),
        .mem_read_enable_o  (mem_read_enable_o),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o)
    );

    ////////////////////
    // Divider
    ////////////////////

    div_fsm u_div_fsm (
        .clk     (clk),
        .reset_n (reset_n),
        .op_i    (op_i),
        .valid_i (op_valid_i),
        .ctrl    (div_ctrl)
    );

    div_step_counter u_div_step_counter (
        .clk     (clk),
        .reset_n (reset_n),
        .ctrl    (div_ctrl)
    );

    div_datapath u_div_datapath (
        .clk        (clk),
        .reset_n    (reset_n),
        .op_i       (op_i),
        .dividend_i (rs1_data_i),
        .divisor_i  (rs2_data_i),
        .ctrl       (div_ctrl),
        .result_o   (div_result)
    );

    // Destination kept for the whole division
    always_ff @(posedge clk) begin
        if (div_ctrl.start) begin
            div_rd <= rd_i;
        end
    end

    ////////////////////
    // Result and jumps
    ////////////////////

    always_comb begin
        unique case (op_i)
            exec_pkg::JAL,
            exec_pkg::JALR:  result = pc_next_i;
            exec_pkg::AUIPC: result = jump_imm_target_i;
            default:         result = alu_result;
        endcase
    end

    always_comb begin
        unique case (op_i)
            exec_pkg::NOP,
            exec_pkg::SB, exec_pkg::SH, exec_pkg::SW,
            exec_pkg::BEQ, exec_pkg::BNE, exec_pkg::BLT,
            exec_pkg::BLTU, exec_pkg::BGE, exec_pkg::BGEU,
            exec_pkg::DIV, exec_pkg::DIVU,
            exec_pkg::REM, exec_pkg::REMU: write_enable = 1'b0;
            default:                       write_enable = issue_valid && (rd_i != '0);
        endcase
    end

    assign jump_o        = issue_valid && take_branch;
    assign jump_target_o = (op_i == exec_pkg::JALR) ? {sum[31:1], 1'b0} : jump_imm_target_i;

    ////////////////////
    // Output registers
    ////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            write_enable_o <= 1'b0;
            rd_o           <= '0;
            result_o       <= '0;
        end else if (div_ctrl.done) begin
            write_enable_o <= (div_rd != '0);
            rd_o           <= div_rd;
            result_o       <= div_result;
        end else begin
            write_enable_o <= write_enable;
            if (issue_valid) begin
                rd_o     <= rd_i;
                result_o <= result;
            end
        end
    end

endmodule

// File: tb_execute.sv
`timescale 1ns/1ps

module tb_execute;

    localparam int CLK_HALF    = 10;
    localparam int RAND_PER_OP = 6;

    // Issues over the whole run, each one shorter than a division plus slack
    localparam int TEST_COUNT  = 12 * (RAND_PER_OP + 1) + 16 * RAND_PER_OP
                                 + 4 * (RAND_PER_OP + 3);
    localparam int WATCHDOG_NS = TEST_COUNT * (exec_pkg::DIV_LATENCY + 4) * 2 * CLK_HALF
                                 + 2000;

    logic               clk;
    logic               reset_n;
    logic               op_valid_i;
    exec_pkg::op_e      op_i;
    exec_pkg::word_t    rs1_data_i;
    exec_pkg::word_t    rs2_data_i;
    exec_pkg::word_t    second_operand_i;
    exec_pkg::reg_idx_t rd_i;
    exec_pkg::word_t    pc_next_i;
    exec_pkg::word_t    jump_imm_target_i;
    logic               hold_o;
    logic               write_enable_o;
    exec_pkg::reg_idx_t rd_o;
    exec_pkg::word_t    result_o;
    logic               jump_o;
    exec_pkg::word_t    jump_target_o;
    exec_pkg::word_t    mem_address_o;
    logic               mem_read_enable_o;
    exec_pkg::byte_en_t mem_write_enable_o;
    exec_pkg::word_t    mem_write_data_o;

    integer seed;

    exec_pkg::op_e alu_ops [12] = '{exec_pkg::ADD, exec_pkg::SUB, exec_pkg::AND, exec_pkg::OR,
                                    exec_pkg::XOR, exec_pkg::SLL, exec_pkg::SRL, exec_pkg::SRA,
                                    exec_pkg::SLT, exec_pkg::SLTU, exec_pkg::LUI,
                                    exec_pkg::AUIPC};
    exec_pkg::op_e flow_ops [8] = '{exec_pkg::BEQ, exec_pkg::BNE, exec_pkg::BLT, exec_pkg::BLTU,
                                    exec_pkg::BGE, exec_pkg::BGEU, exec_pkg::JAL,
                                    exec_pkg::JALR};
    exec_pkg::op_e mem_ops [8]  = '{exec_pkg::LB, exec_pkg::LBU, exec_pkg::LH, exec_pkg::LHU,
                                    exec_pkg::LW, exec_pkg::SB, exec_pkg::SH, exec_pkg::SW};
    exec_pkg::op_e div_ops [4]  = '{exec_pkg::DIV, exec_pkg::DIVU, exec_pkg::REM,
                                    exec_pkg::REMU};

    execute_top DUT (
        .clk                (clk),
        .reset_n            (reset_n),
        .op_valid_i         (op_valid_i),
        .op_i               (op_i),
        .rs1_data_i         (rs1_data_i),
        .rs2_data_i         (rs2_data_i),
        .second_operand_i   (second_operand_i),
        .rd_i               (rd_i),
        .pc_next_i          (pc_next_i),
        .jump_imm_target_i  (jump_imm_target_i),
        .hold_o             (hold_o),
        .write_enable_o     (write_enable_o),
        .rd_o               (rd_o),
        .result_o           (result_o),
        .jump_o             (jump_o),
        .jump_target_o      (jump_target_o),
        .mem_address_o      (mem_address_o),
        .mem_read_enable_o  (mem_read_enable_o),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o)
    );

    initial clk = 1'b0;

    always #CLK_HALF clk = ~clk;

    ////////////////////
    // Reference model
    ////////////////////

    function automatic exec_pkg::word_t model_result(exec_pkg::op_e op, exec_pkg::word_t a,
            exec_pkg::word_t b, exec_pkg::word_t pc_next, exec_pkg::word_t imm_target);
        case (op)
            exec_pkg::ADD:   return a + b;
            exec_pkg::SUB:   return a - b;
            exec_pkg::AND:   return a & b;
            exec_pkg::OR:    return a | b;
            exec_pkg::XOR:   return a ^ b;
            exec_pkg::SLL:   return a << b[4:0];
            exec_pkg::SRL:   return a >> b[4:0];
            exec_pkg::SRA:   return $signed(a) >>> b[4:0];
            exec_pkg::SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exec_pkg::SLTU:  return (a < b) ? 32'd1 : 32'd0;
            exec_pkg::LUI:   return b;
            exec_pkg::AUIPC: return imm_target;
            exec_pkg::JAL,
            exec_pkg::JALR:  return pc_next;
            default:         return '0;
        endcase
    endfunction

    function automatic logic model_taken(exec_pkg::op_e op, exec_pkg::word_t a,
            exec_pkg::word_t b);
        case (op)
            exec_pkg::BEQ:  return a == b;
            exec_pkg::BNE:  return a != b;
            exec_pkg::BLT:  return $signed(a) < $signed(b);
            exec_pkg::BLTU: return a < b;
            exec_pkg::BGE:  return $signed(a) >= $signed(b);
            exec_pkg::BGEU: return a >= b;
            exec_pkg::JAL,
            exec_pkg::JALR: return 1'b1;
            default:        return 1'b0;
        endcase
    endfunction

    // Register write rule for everything except divisions
    function automatic logic model_writes(exec_pkg::op_e op, exec_pkg::reg_idx_t rd);
        if (rd == '0) begin
            return 1'b0;
        end
        case (op)
            exec_pkg::NOP, exec_pkg::SB, exec_pkg::SH, exec_pkg::SW,
            exec_pkg::BEQ, exec_pkg::BNE, exec_pkg::BLT,
            exec_pkg::BLTU, exec_pkg::BGE, exec_pkg::BGEU: return 1'b0;
            default:                                       return 1'b1;
        endcase
    endfunction

    function automatic exec_pkg::byte_en_t model_lanes(exec_pkg::op_e op, exec_pkg::word_t addr);
        case (op)
            exec_pkg::SB: return 4'b0001 << addr[1:0];
            exec_pkg::SH: return addr[1] ? 4'b1100 : 4'b0011;
            exec_pkg::SW: return 4'b1111;
            default:      return 4'b0000;
        endcase
    endfunction

    function automatic exec_pkg::word_t model_store_data(exec_pkg::op_e op, exec_pkg::word_t d);
        case (op)
            exec_pkg::SB: return {d[7:0], d[7:0], d[7:0], d[7:0]};
            exec_pkg::SH: return {d[15:0], d[15:0]};
            default:      return d;
        endcase
    endfunction

    // Divide by zero and signed overflow follow the ISA rules
    function automatic exec_pkg::word_t model_div(exec_pkg::op_e op, exec_pkg::word_t a,
            exec_pkg::word_t b);
        logic is_quotient;
        logic is_signed;
        is_quotient = (op == exec_pkg::DIV) || (op == exec_pkg::DIVU);
        is_signed   = (op == exec_pkg::DIV) || (op == exec_pkg::REM);
        if (b == '0) begin
            return is_quotient ? 32'hffff_ffff : a;
        end
        if (is_signed && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            return is_quotient ? 32'h8000_0000 : 32'd0;
        end
        case (op)
            exec_pkg::DIV:  return $signed(a) / $signed(b);
            exec_pkg::DIVU: return a / b;
            exec_pkg::REM:  return $signed(a) % $signed(b);
            default:        return a % b;
        endcase
    endfunction

    function automatic exec_pkg::reg_idx_t pick_rd();
        exec_pkg::reg_idx_t rd;
        rd = $random(seed);
        if (rd == '0) begin
            rd = 5'd1;
        end
        return rd;
    endfunction

    ////////////////////
    // Checks
    ////////////////////

    task automatic report_mismatch(input string what, input exec_pkg::word_t got,
            input exec_pkg::word_t expected);
        $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic abort_run(input string what);
        $display("Error at %0t ns: %s", $time, what);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic expect_word(input string what, input exec_pkg::word_t got,
            input exec_pkg::word_t expected);
        assert (got === expected)
            else report_mismatch(what, got, expected);
    endtask

    // Nothing is written back while the divider holds the stage
    assert property (@(posedge clk) disable iff (!reset_n) hold_o |-> !write_enable_o)
        else abort_run("write_enable_o was high while hold_o was high");

    // Register zero is never written
    assert property (@(posedge clk) disable iff (!reset_n) write_enable_o |-> rd_o != '0)
        else abort_run("write_enable_o was high with rd_o zero");

    assert property (@(posedge clk) disable iff (!reset_n)
            !op_valid_i |-> !jump_o && !mem_read_enable_o && mem_write_enable_o == 4'b0000)
        else abort_run("jump or memory enable was high without an issue strobe");

    ////////////////////
    // Stimulus
    ////////////////////

    // Inputs change on the rising edge, outputs are sampled on the falling edge
    task automatic drive_op(input exec_pkg::op_e op, input exec_pkg::word_t a,
            input exec_pkg::word_t b, input exec_pkg::word_t rs2, input exec_pkg::reg_idx_t rd,
            input exec_pkg::word_t pc_next, input exec_pkg::word_t imm_target);
        @(posedge clk);
        op_valid_i        <= 1'b1;
        op_i              <= op;
        rs1_data_i        <= a;
        second_operand_i  <= b;
        rs2_data_i        <= rs2;
        rd_i              <= rd;
        pc_next_i         <= pc_next;
        jump_imm_target_i <= imm_target;
        @(negedge clk);
    endtask

    // The opcode stays on the bus, only the strobe drops
    task automatic release_op();
        @(posedge clk);
        op_valid_i <= 1'b0;
        @(negedge clk);
    endtask

    task automatic exercise_alu(input exec_pkg::op_e op, input exec_pkg::reg_idx_t rd);
        exec_pkg::word_t a;
        exec_pkg::word_t b;
        exec_pkg::word_t pc_next;
        exec_pkg::word_t imm;
        exec_pkg::word_t expected;
        logic            writes;
        a        = $random(seed);
        b        = $random(seed);
        pc_next  = $random(seed);
        imm      = $random(seed);
        expected = model_result(op, a, b, pc_next, imm);
        writes   = model_writes(op, rd);
        drive_op(op, a, b, $random(seed), rd, pc_next, imm);
        expect_word($sformatf("%s jump_o", op.name()), jump_o, 1'b0);
        expect_word($sformatf("%s mem_read_enable_o", op.name()), mem_read_enable_o, 1'b0);
        release_op();
        expect_word($sformatf("%s write_enable_o", op.name()), write_enable_o, writes);
        if (writes) begin
            expect_word($sformatf("%s rd_o", op.name()), rd_o, rd);
            expect_word($sformatf("%s result_o", op.name()), result_o, expected);
        end
    endtask

    task automatic exercise_flow(input exec_pkg::op_e op, input logic equal_operands);
        exec_pkg::word_t    a;
        exec_pkg::word_t    b;
        exec_pkg::word_t    pc_next;
        exec_pkg::word_t    imm;
        exec_pkg::word_t    target;
        exec_pkg::reg_idx_t rd;
        logic               writes;
        a       = $random(seed);
        b       = equal_operands ? a : $random(seed);
        pc_next = $random(seed);
        imm     = $random(seed);
        rd      = pick_rd();
        writes  = model_writes(op, rd);
        target  = (op == exec_pkg::JALR) ? ((a + b) & ~32'd1) : imm;
        drive_op(op, a, b, $random(seed), rd, pc_next, imm);
        expect_word($sformatf("%s jump_o", op.name()), jump_o, model_taken(op, a, b));
        expect_word($sformatf("%s jump_target_o", op.name()), jump_target_o, target);
        release_op();
        expect_word($sformatf("%s write_enable_o", op.name()), write_enable_o, writes);
        if (writes) begin
            expect_word($sformatf("%s rd_o", op.name()), rd_o, rd);
            expect_word($sformatf("%s result_o", op.name()), result_o, pc_next);
        end
    endtask

    task automatic exercise_memory(input exec_pkg::op_e op);
        exec_pkg::word_t    a;
        exec_pkg::word_t    b;
        exec_pkg::word_t    data;
        exec_pkg::word_t    addr;
        exec_pkg::reg_idx_t rd;
        logic               is_load;
        a       = $random(seed);
        b       = $random(seed);
        data    = $random(seed);
        addr    = a + b;
        rd      = pick_rd();
        is_load = op inside {exec_pkg::LB, exec_pkg::LBU, exec_pkg::LH, exec_pkg::LHU,
                             exec_pkg::LW};
        drive_op(op, a, b, data, rd, $random(seed), $random(seed));
        expect_word($sformatf("%s mem_address_o", op.name()), mem_address_o,
                    {addr[31:2], 2'b00});
        expect_word($sformatf("%s mem_read_enable_o", op.name()), mem_read_enable_o, is_load);
        expect_word($sformatf("%s mem_write_enable_o", op.name()), mem_write_enable_o,
                    model_lanes(op, addr));
        if (!is_load) begin
            expect_word($sformatf("%s mem_write_data_o", op.name()), mem_write_data_o,
                        model_store_data(op, data));
        end
        release_op();
        expect_word($sformatf("%s write_enable_o", op.name()), write_enable_o,
                    model_writes(op, rd));
    endtask

    // Checks hold_o and write_enable_o on every cycle up to the result
    task automatic exercise_division(input exec_pkg::op_e op, input exec_pkg::word_t a,
            input exec_pkg::word_t b, input exec_pkg::reg_idx_t rd);
        exec_pkg::word_t expected;
        expected = model_div(op, a, b);
        drive_op(op, a, $random(seed), b, rd, $random(seed), $random(seed));
        expect_word($sformatf("%s hold_o in strobe cycle", op.name()), hold_o, 1'b0);
        release_op();
        for (int cycle = 1; cycle < exec_pkg::DIV_LATENCY; cycle++) begin
            expect_word($sformatf("%s hold_o at cycle %0d", op.name(), cycle), hold_o, 1'b1);
            expect_word($sformatf("%s write_enable_o at cycle %0d", op.name(), cycle),
                        write_enable_o, 1'b0);
            @(negedge clk);
        end
        expect_word($sformatf("%s hold_o at the result", op.name()), hold_o, 1'b0);
        expect_word($sformatf("%s write_enable_o at the result", op.name()), write_enable_o,
                    rd != '0);
        if (rd != '0) begin
            expect_word($sformatf("%s rd_o", op.name()), rd_o, rd);
            expect_word($sformatf("%s result_o of %h by %h", op.name(), a, b), result_o,
                        expected);
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        exec_pkg::word_t a;
        exec_pkg::word_t b;
        seed              = 32'hbb9d2fa9;
        reset_n           = 1'b0;
        op_valid_i        = 1'b0;
        op_i              = exec_pkg::NOP;
        rs1_data_i        = '0;
        rs2_data_i        = '0;
        second_operand_i  = '0;
        rd_i              = '0;
        pc_next_i         = '0;
        jump_imm_target_i = '0;
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);

        // Control outputs idle after reset
        expect_word("hold_o after reset", hold_o, 1'b0);
        expect_word("write_enable_o after reset", write_enable_o, 1'b0);
        expect_word("jump_o after reset", jump_o, 1'b0);
        expect_word("mem_read_enable_o after reset", mem_read_enable_o, 1'b0);
        expect_word("mem_write_enable_o after reset", mem_write_enable_o, 4'b0000);
        expect_word("rd_o after reset", rd_o, '0);
        expect_word("result_o after reset", result_o, '0);

        foreach (alu_ops[i]) begin
            for (int n = 0; n < RAND_PER_OP; n++) begin
                exercise_alu(alu_ops[i], pick_rd());
            end
            exercise_alu(alu_ops[i], 5'd0);
        end

        foreach (flow_ops[i]) begin
            for (int n = 0; n < RAND_PER_OP; n++) begin
                exercise_flow(flow_ops[i], n[0]);
            end
        end

        foreach (mem_ops[i]) begin
            for (int n = 0; n < RAND_PER_OP; n++) begin
                exercise_memory(mem_ops[i]);
            end
        end

        foreach (div_ops[i]) begin
            for (int n = 0; n < RAND_PER_OP; n++) begin
                a = $random(seed);
                b = $random(seed);
                // Short divisors give large quotients
                if (n[0]) begin
                    b = {{20{b[31]}}, b[31:20]};
                end
                exercise_division(div_ops[i], a, b, pick_rd());
            end
            exercise_division(div_ops[i], $random(seed), 32'd0, pick_rd());
            exercise_division(div_ops[i], 32'h8000_0000, 32'hffff_ffff, pick_rd());
            exercise_division(div_ops[i], $random(seed), 32'd7, 5'd0);
        end

        @(posedge clk);
        $display("PASS: all tests");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the test sequence did not finish in the expected time");
        $display("FAIL: see errors above");
        $fatal(1);
    end

endmodule

// File: filelist.f
exec_pkg.sv
div_ctrl_if.sv
alu.sv
mem_access.sv
div_fsm.sv
div_step_counter.sv
div_datapath.sv
execute_top.sv
tb_execute.sv
